/* hw/wb_csr_settings.svh */
`ifndef WB_CSR_SETTINGS_SVH
`define WB_CSR_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data and PC width
`define WB_DATA_W 32

// CSR number field of csrrd/csrwr/csrxchg
`define WB_CSR_NUM_W 14

`define WB_ECODE_W 6

`define WB_REG_ADDR_W 5

// TCFG.InitVal, the count is this field shifted left by two
`define WB_TIMER_INIT_W 30

// ESTAT.IS and ECFG.LIE
`define WB_INT_W 13

`endif

/* hw/wb_csr_pkg.sv */
`include "wb_csr_settings.svh"

package wb_csr_pkg;

	// Instruction kind as seen by write-back
	typedef enum logic [2:0] {
		op_none,
		op_csrrd,
		op_csrwr,
		op_csrxchg,
		op_ertn,
		op_rdcntid
	} csr_op_e;

	// Architectural CSR numbers
	typedef enum logic [`WB_CSR_NUM_W-1:0] {
		csr_crmd   = 'h00,
		csr_prmd   = 'h01,
		csr_ecfg   = 'h04,
		csr_estat  = 'h05,
		csr_era    = 'h06,
		csr_eentry = 'h0c,
		csr_save0  = 'h30,
		csr_save1  = 'h31,
		csr_save2  = 'h32,
		csr_save3  = 'h33,
		csr_tid    = 'h40,
		csr_tcfg   = 'h41,
		csr_tval   = 'h42,
		csr_ticlr  = 'h44
	} csr_num_e;

	typedef enum logic [`WB_ECODE_W-1:0] {
		ecode_int = 'h00,
		ecode_sys = 'h0b,
		ecode_brk = 'h0c,
		ecode_ine = 'h0d
	} ecode_e;

endpackage

/* hw/wb_input_reg.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module wb_input_reg
	import wb_csr_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  logic [`WB_DATA_W-1:0]     in_pc,
	input  csr_op_e                   in_op,
	input  csr_num_e                  in_csr_num,
	input  logic [`WB_DATA_W-1:0]     in_result,
	input  logic [`WB_DATA_W-1:0]     in_mask,
	input  logic                      in_gr_we,
	input  logic [`WB_REG_ADDR_W-1:0] in_dest,
	input  logic                      in_ex,
	input  ecode_e                    in_ecode,
	input  logic                      flush,
	output logic                      allowin,
	output logic                      ws_valid,
	output logic [`WB_DATA_W-1:0]     ws_pc,
	output csr_op_e                   ws_op,
	output csr_num_e                  ws_csr_num,
	output logic [`WB_DATA_W-1:0]     ws_result,
	output logic [`WB_DATA_W-1:0]     ws_mask,
	output logic                      ws_gr_we,
	output logic [`WB_REG_ADDR_W-1:0] ws_dest,
	output logic                      ws_ex,
	output ecode_e                    ws_ecode
);

logic take;

// Register file never stalls, so every item retires in its cycle
assign allowin = 1'b1;

// Item arriving while the held one traps or returns is dropped
assign take = in_valid && !flush;

always_ff @(posedge clk) begin
	if (reset) begin
		ws_valid <= 1'b0;
		ws_op    <= op_none;
	end else if (allowin) begin
		ws_valid <= take;
		ws_op    <= take ? in_op : op_none;
	end
end

always_ff @(posedge clk) begin
	if (in_valid && allowin) begin
		ws_pc      <= in_pc;
		ws_csr_num <= in_csr_num;
		ws_result  <= in_result;
		ws_mask    <= in_mask;
		ws_gr_we   <= in_gr_we;
		ws_dest    <= in_dest;
		ws_ex      <= in_ex;
		ws_ecode   <= in_ecode;
	end
end

endmodule

/* hw/csr_file.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module csr_file
	import wb_csr_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ws_valid,
	input  csr_op_e               ws_op,
	input  csr_num_e              ws_csr_num,
	input  logic [`WB_DATA_W-1:0] ws_result,
	input  logic [`WB_DATA_W-1:0] ws_mask,
	input  logic [`WB_DATA_W-1:0] ws_pc,
	input  logic                  trap,
	input  ecode_e                trap_ecode,
	input  logic                  eret,
	input  logic [`WB_DATA_W-1:0] tcfg_rdata,
	input  logic [`WB_DATA_W-1:0] tval_rdata,
	input  logic                  timer_irq,
	output logic [`WB_DATA_W-1:0] csr_rdata,
	output logic [`WB_DATA_W-1:0] tid,
	output logic                  int_pending,
	output logic [`WB_DATA_W-1:0] eentry_base,
	output logic [2:0]            ecfg_vs,
	output logic [`WB_DATA_W-1:0] era,
	output logic                  tcfg_we,
	output logic                  ticlr_we,
	output logic [`WB_DATA_W-1:0] csr_wdata
);

// Timer line 11 and software lines 1:0
localparam logic [`WB_INT_W-1:0] int_lines = `WB_INT_W'h0803;

logic [1:0]               crmd_plv;
logic                     crmd_ie;
logic [1:0]               prmd_pplv;
logic                     prmd_pie;
logic [`WB_INT_W-1:0]     ecfg_lie;
logic [1:0]               estat_is_sw;
ecode_e                   estat_ecode;
logic [`WB_INT_W-1:0]     estat_is;
logic [`WB_DATA_W-1:12]   eentry_va;
logic [`WB_DATA_W-1:0]    save [4];
logic                     csr_we;

always_comb begin
	estat_is = '0;
	estat_is[11] = timer_irq;
	estat_is[1:0] = estat_is_sw;
end

assign eentry_base = {eentry_va, 12'b0};

//////////////////////////////////////////////////////////////////////
// Read mux, reserved fields read as zero
//////////////////////////////////////////////////////////////////////

always_comb begin
	case (ws_csr_num)
		csr_crmd:   csr_rdata = {{(`WB_DATA_W-3){1'b0}}, crmd_ie, crmd_plv};
		csr_prmd:   csr_rdata = {{(`WB_DATA_W-3){1'b0}}, prmd_pie, prmd_pplv};
		csr_ecfg:   csr_rdata = {{(`WB_DATA_W-19){1'b0}}, ecfg_vs,
				{(16-`WB_INT_W){1'b0}}, ecfg_lie};
		csr_estat:  csr_rdata = {{(`WB_DATA_W-16-`WB_ECODE_W){1'b0}}, estat_ecode,
				{(16-`WB_INT_W){1'b0}}, estat_is};
		csr_era:    csr_rdata = era;
		csr_eentry: csr_rdata = eentry_base;
		csr_save0,
		csr_save1,
		csr_save2,
		csr_save3:  csr_rdata = save[ws_csr_num[1:0]];
		csr_tid:    csr_rdata = tid;
		csr_tcfg:   csr_rdata = tcfg_rdata;
		csr_tval:   csr_rdata = tval_rdata;
		default:    csr_rdata = '0;
	endcase
end

// Exchange keeps the old bits where the mask is clear
assign csr_wdata = (ws_op == op_csrxchg) ?
	((ws_mask & ws_result) | (~ws_mask & csr_rdata)) : ws_result;

// An item that traps leaves the CSRs alone
assign csr_we = ws_valid && !trap && (ws_op == op_csrwr || ws_op == op_csrxchg);

assign tcfg_we  = csr_we && (ws_csr_num == csr_tcfg);
assign ticlr_we = csr_we && (ws_csr_num == csr_ticlr);

//////////////////////////////////////////////////////////////////////
// Mode and interrupt control
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (reset) begin
		crmd_plv  <= 2'b0;
		crmd_ie   <= 1'b0;
		prmd_pplv <= 2'b0;
		prmd_pie  <= 1'b0;
	end else if (trap) begin
		prmd_pplv <= crmd_plv;
		prmd_pie  <= crmd_ie;
		crmd_plv  <= 2'b0;
		crmd_ie   <= 1'b0;
	end else if (eret) begin
		crmd_plv <= prmd_pplv;
		crmd_ie  <= prmd_pie;
	end else if (csr_we && ws_csr_num == csr_crmd) begin
		crmd_plv <= csr_wdata[1:0];
		crmd_ie  <= csr_wdata[2];
	end else if (csr_we && ws_csr_num == csr_prmd) begin
		prmd_pplv <= csr_wdata[1:0];
		prmd_pie  <= csr_wdata[2];
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		ecfg_lie    <= '0;
		ecfg_vs     <= 3'b0;
		estat_is_sw <= 2'b0;
	end else if (csr_we && ws_csr_num == csr_ecfg) begin
		ecfg_lie <= csr_wdata[`WB_INT_W-1:0] & int_lines;
		ecfg_vs  <= csr_wdata[18:16];
	end else if (csr_we && ws_csr_num == csr_estat) begin
		estat_is_sw <= csr_wdata[1:0];
	end
end

assign int_pending = |(estat_is & ecfg_lie) && crmd_ie;

//////////////////////////////////////////////////////////////////////
// Data CSRs
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (trap) begin
		estat_ecode <= trap_ecode;
		era         <= ws_pc;
	end else if (csr_we && ws_csr_num == csr_era) begin
		era <= csr_wdata;
	end
end

always_ff @(posedge clk) begin
	if (csr_we) begin
		case (ws_csr_num)
			csr_eentry: eentry_va <= csr_wdata[`WB_DATA_W-1:12];
			csr_save0,
			csr_save1,
			csr_save2,
			csr_save3:  save[ws_csr_num[1:0]] <= csr_wdata;
			csr_tid:    tid <= csr_wdata;
			default:    ;
		endcase
	end
end

// Commit logic must never report a trap and a return at once
trap_eret_excl: assert property (
	@(posedge clk) disable iff (reset)
	!(trap && eret)
);

endmodule

/* hw/csr_timer.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module csr_timer
	import wb_csr_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  tcfg_we,
	input  logic                  ticlr_we,
	input  logic [`WB_DATA_W-1:0] csr_wdata,
	output logic [`WB_DATA_W-1:0] tcfg_rdata,
	output logic [`WB_DATA_W-1:0] tval_rdata,
	output logic                  timer_irq
);

logic                        tcfg_en;
logic                        tcfg_periodic;
logic [`WB_TIMER_INIT_W-1:0] tcfg_initval;
logic [`WB_DATA_W-1:0]       tval;
logic                        running;
logic                        expired;

// Counter hit zero in this cycle
assign expired = running && (tval == '0);

always_ff @(posedge clk) begin
	if (reset) begin
		tcfg_en       <= 1'b0;
		tcfg_periodic <= 1'b0;
		tcfg_initval  <= '0;
		tval          <= '0;
		running       <= 1'b0;
	end else if (tcfg_we) begin
		tcfg_en       <= csr_wdata[0];
		tcfg_periodic <= csr_wdata[1];
		tcfg_initval  <= csr_wdata[`WB_DATA_W-1:2];
		tval          <= {csr_wdata[`WB_DATA_W-1:2], 2'b00};
		running       <= csr_wdata[0];
	end else if (expired) begin
		// Periodic reloads, one-shot holds at zero
		if (tcfg_periodic) begin
			tval <= {tcfg_initval, 2'b00};
		end else begin
			running <= 1'b0;
		end
	end else if (running) begin
		tval <= tval - 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		timer_irq <= 1'b0;
	end else if (ticlr_we && csr_wdata[0]) begin
		timer_irq <= 1'b0;
	end else if (expired) begin
		timer_irq <= 1'b1;
	end
end

assign tcfg_rdata = {tcfg_initval, tcfg_periodic, tcfg_en};
assign tval_rdata = tval;

tval_frozen_when_off: assert property (
	@(posedge clk) disable iff (reset)
	(!tcfg_en && !tcfg_we) |=> $stable(tval)
);

endmodule

/* hw/wb_commit.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module wb_commit
	import wb_csr_pkg::*;
(
	input  logic                      ws_valid,
	input  csr_op_e                   ws_op,
	input  logic                      ws_ex,
	input  ecode_e                    ws_ecode,
	input  logic                      ws_gr_we,
	input  logic [`WB_REG_ADDR_W-1:0] ws_dest,
	input  logic [`WB_DATA_W-1:0]     ws_result,
	input  logic [`WB_DATA_W-1:0]     csr_rdata,
	input  logic [`WB_DATA_W-1:0]     tid,
	input  logic                      int_pending,
	input  logic [`WB_DATA_W-1:0]     eentry_base,
	input  logic [2:0]                ecfg_vs,
	input  logic [`WB_DATA_W-1:0]     era,
	output logic                      trap,
	output ecode_e                    trap_ecode,
	output logic                      eret,
	output logic                      flush,
	output logic [`WB_DATA_W-1:0]     flush_pc,
	output logic                      rf_we,
	output logic [`WB_REG_ADDR_W-1:0] rf_waddr,
	output logic [`WB_DATA_W-1:0]     rf_wdata
);

logic [`WB_DATA_W-1:0] trap_entry;

//////////////////////////////////////////////////////////////////////
// Trap and return decision
//////////////////////////////////////////////////////////////////////

// Interrupt wins over the exception carried by the item
assign trap       = ws_valid && (ws_ex || int_pending);
assign trap_ecode = int_pending ? ecode_int : ws_ecode;
assign eret       = ws_valid && (ws_op == op_ertn) && !trap;
assign flush      = trap || eret;

// Vectored entry spaces handlers by four bytes per ecode
assign trap_entry = (ecfg_vs == 3'b0) ? eentry_base :
	eentry_base + {{(`WB_DATA_W-`WB_ECODE_W-2){1'b0}}, trap_ecode, 2'b00};

assign flush_pc = trap ? trap_entry : era;

//////////////////////////////////////////////////////////////////////
// Register file port
//////////////////////////////////////////////////////////////////////

always_comb begin
	case (ws_op)
		op_csrrd,
		op_csrwr,
		op_csrxchg: rf_wdata = csr_rdata;
		op_rdcntid: rf_wdata = tid;
		default:    rf_wdata = ws_result;
	endcase
end

assign rf_we    = ws_valid && ws_gr_we && !trap;
assign rf_waddr = ws_dest;

endmodule

/* hw/wb_csr_top.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module wb_csr_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  logic [`WB_DATA_W-1:0]     in_pc,
	input  wb_csr_pkg::csr_op_e       in_op,
	input  wb_csr_pkg::csr_num_e      in_csr_num,
	input  logic [`WB_DATA_W-1:0]     in_result,
	input  logic [`WB_DATA_W-1:0]     in_mask,
	input  logic                      in_gr_we,
	input  logic [`WB_REG_ADDR_W-1:0] in_dest,
	input  logic                      in_ex,
	input  wb_csr_pkg::ecode_e        in_ecode,
	output logic                      allowin,
	output logic                      rf_we,
	output logic [`WB_REG_ADDR_W-1:0] rf_waddr,
	output logic [`WB_DATA_W-1:0]     rf_wdata,
	output logic                      flush,
	output logic [`WB_DATA_W-1:0]     flush_pc
);

// Held item
logic                      ws_valid;
logic [`WB_DATA_W-1:0]     ws_pc;
wb_csr_pkg::csr_op_e       ws_op;
wb_csr_pkg::csr_num_e      ws_csr_num;
logic [`WB_DATA_W-1:0]     ws_result;
logic [`WB_DATA_W-1:0]     ws_mask;
logic                      ws_gr_we;
logic [`WB_REG_ADDR_W-1:0] ws_dest;
logic                      ws_ex;
wb_csr_pkg::ecode_e        ws_ecode;

// CSR side
logic [`WB_DATA_W-1:0]     csr_rdata;
logic [`WB_DATA_W-1:0]     tid;
logic                      int_pending;
logic [`WB_DATA_W-1:0]     eentry_base;
logic [2:0]                ecfg_vs;
logic [`WB_DATA_W-1:0]     era;
logic                      trap;
wb_csr_pkg::ecode_e        trap_ecode;
logic                      eret;

// Timer side
logic                      tcfg_we;
logic                      ticlr_we;
logic [`WB_DATA_W-1:0]     csr_wdata;
logic [`WB_DATA_W-1:0]     tcfg_rdata;
logic [`WB_DATA_W-1:0]     tval_rdata;
logic                      timer_irq;

wb_input_reg u_input_reg (
	.clk        (clk),
	.reset      (reset),
	.in_valid   (in_valid),
	.in_pc      (in_pc),
	.in_op      (in_op),
	.in_csr_num (in_csr_num),
	.in_result  (in_result),
	.in_mask    (in_mask),
	.in_gr_we   (in_gr_we),
	.in_dest    (in_dest),
	.in_ex      (in_ex),
	.in_ecode   (in_ecode),
	.flush      (flush),
	.allowin    (allowin),
	.ws_valid   (ws_valid),
	.ws_pc      (ws_pc),
	.ws_op      (ws_op),
	.ws_csr_num (ws_csr_num),
	.ws_result  (ws_result),
	.ws_mask    (ws_mask),
	.ws_gr_we   (ws_gr_we),
	.ws_dest    (ws_dest),
	.ws_ex      (ws_ex),
	.ws_ecode   (ws_ecode)
);

csr_file u_csr_file (
	.clk         (clk),
	.reset       (reset),
	.ws_valid    (ws_valid),
	.ws_op       (ws_op),
	.ws_csr_num  (ws_csr_num),
	.ws_result   (ws_result),
	.ws_mask     (ws_mask),
	.ws_pc       (ws_pc),
	.trap        (trap),
	.trap_ecode  (trap_ecode),
	.eret        (eret),
	.tcfg_rdata  (tcfg_rdata),
	.tval_rdata  (tval_rdata),
	.timer_irq   (timer_irq),
	.csr_rdata   (csr_rdata),
	.tid         (tid),
	.int_pending (int_pending),
	.eentry_base (eentry_base),
	.ecfg_vs     (ecfg_vs),
	.era         (era),
	.tcfg_we     (tcfg_we),
	.ticlr_we    (ticlr_we),
	.csr_wdata   (csr_wdata)
);

csr_timer u_csr_timer (
	.clk        (clk),
	.reset      (reset),
	.tcfg_we    (tcfg_we),
	.ticlr_we   (ticlr_we),
	.csr_wdata  (csr_wdata),
	.tcfg_rdata (tcfg_rdata),
	.tval_rdata (tval_rdata),
	.timer_irq  (timer_irq)
);

wb_commit u_commit (
	.ws_valid    (ws_valid),
	.ws_op       (ws_op),
	.ws_ex       (ws_ex),
	.ws_ecode    (ws_ecode),
	.ws_gr_we    (ws_gr_we),
	.ws_dest     (ws_dest),
	.ws_result   (ws_result),
	.csr_rdata   (csr_rdata),
	.tid         (tid),
	.int_pending (int_pending),
	.eentry_base (eentry_base),
	.ecfg_vs     (ecfg_vs),
	.era         (era),
	.trap        (trap),
	.trap_ecode  (trap_ecode),
	.eret        (eret),
	.flush       (flush),
	.flush_pc    (flush_pc),
	.rf_we       (rf_we),
	.rf_waddr    (rf_waddr),
	.rf_wdata    (rf_wdata)
);

endmodule

/* testbench/tb_wb_csr_vectors.svh */
`ifndef TB_WB_CSR_VECTORS_SVH
`define TB_WB_CSR_VECTORS_SVH

task automatic load_vectors();
	logic [31:0] v0a, v0b, v1, v2, v3, merged, p1;
	v0a    = $urandom;
	v0b    = $urandom;
	v1     = $urandom;
	v2     = $urandom;
	v3     = $urandom;
	// Source bytes 2 and 0 over old bytes 3 and 1
	merged = 32'h00ff0000 | (v1 & 32'hff00ff00);
	// op, csr, ex, ecode, src, mask, gr_we, exp_we, exp_wdata, exp_flush, exp_fpc, idle
	// Write then read, csrwr returns the old value
	add_row(op_csrwr,   csr_save0,  0, ecode_int, v0a,         0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrwr,   csr_save0,  0, ecode_int, v0b,         0, 1, 1, v0a, 0, 0, 0);
	add_row(op_csrrd,   csr_save0,  0, ecode_int, 0,           0, 1, 1, v0b, 0, 0, 0);
	add_row(op_csrwr,   csr_save1,  0, ecode_int, v1,          0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrwr,   csr_save2,  0, ecode_int, v2,          0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrwr,   csr_save3,  0, ecode_int, v3,          0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrrd,   csr_save1,  0, ecode_int, 0,           0, 1, 1, v1,  0, 0, 0);
	add_row(op_csrrd,   csr_save2,  0, ecode_int, 0,           0, 1, 1, v2,  0, 0, 0);
	add_row(op_csrrd,   csr_save3,  0, ecode_int, 0,           0, 1, 1, v3,  0, 0, 0);
	add_row(op_csrwr,   csr_era,    0, ecode_int, 'h1c008000,  0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrrd,   csr_era,    0, ecode_int, 0,  0, 1, 1, 'h1c008000,   0, 0, 0);
	add_row(op_csrwr,   csr_eentry, 0, ecode_int, 'h1c001abc,  0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrrd,   csr_eentry, 0, ecode_int, 0,  0, 1, 1, 'h1c001000,   0, 0, 0);
	add_row(op_csrwr,   csr_eentry, 0, ecode_int, 'h1c002000, 0, 1, 1, 'h1c001000, 0, 0, 0);
	// Exchange, masked source over old value
	add_row(op_csrxchg, csr_save1, 0, ecode_int, 'hffff0000, 'h00ff00ff, 1, 1, v1, 0, 0, 0);
	add_row(op_csrrd,   csr_save1,  0, ecode_int, 0,           0, 1, 1, merged, 0, 0, 0);
	// Exception entry with VS zero, next item dropped
	add_row(op_csrwr,   csr_crmd,   0, ecode_int, 'h7,         0, 0, 0, 0,   0, 0, 0);
	add_row(op_none,    csr_crmd,   1, ecode_sys, 'h55,  0, 1, 0, 0, 1, 'h1c002000, 0);
	p1 = last_pc;
	add_row(op_none,    csr_crmd,   0, ecode_int, 'h66,        0, 1, 0, 0,   0, 0, 0);
	add_row(op_csrrd,   csr_era,    0, ecode_int, 0,           0, 1, 1, p1,  0, 0, 0);
	add_row(op_csrrd,   csr_estat,  0, ecode_int, 0,  0, 1, 1, 'h000b0000,   0, 0, 0);
	add_row(op_csrrd,   csr_prmd,   0, ecode_int, 0,           0, 1, 1, 'h7, 0, 0, 0);
	add_row(op_csrrd,   csr_crmd,   0, ecode_int, 0,           0, 1, 1, 'h0, 0, 0, 0);
	// Return restores CRMD from PRMD
	add_row(op_ertn,    csr_crmd,   0, ecode_int, 0,           0, 0, 0, 0,   1, p1, 1);
	add_row(op_csrrd,   csr_crmd,   0, ecode_int, 0,           0, 1, 1, 'h7, 0, 0, 0);
	// Vectored entry, base plus ecode times four
	add_row(op_csrwr,   csr_ecfg,   0, ecode_int, 'h00010000,  0, 0, 0, 0,   0, 0, 0);
	add_row(op_none,    csr_crmd,   1, ecode_brk, 0,     0, 0, 0, 0, 1, 'h1c002030, 1);
	// One-shot timer, initval 3
	add_row(op_csrwr,   csr_crmd,   0, ecode_int, 'h4,         0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrwr,   csr_tcfg,   0, ecode_int, 'hd,         0, 0, 0, 0,   0, 0, 20);
	add_row(op_csrrd,   csr_estat,  0, ecode_int, 0,  0, 1, 1, 'h000c0800,   0, 0, 0);
	add_row(op_csrwr,   csr_ecfg,   0, ecode_int, 'h00010800,  0, 0, 0, 0,   0, 0, 0);
	add_row(op_none,    csr_crmd,   0, ecode_int, 'h77,  0, 1, 0, 0, 1, 'h1c002000, 1);
	add_row(op_csrwr,   csr_ticlr,  0, ecode_int, 'h1,         0, 0, 0, 0,   0, 0, 0);
	add_row(op_csrrd,   csr_estat,  0, ecode_int, 0,           0, 1, 1, 'h0, 0, 0, 0);
	// Timer ID and plain result write-back
	add_row(op_csrwr,   csr_tid,    0, ecode_int, 'h00000a5c,  0, 0, 0, 0,   0, 0, 0);
	add_row(op_rdcntid, csr_crmd,   0, ecode_int, 0,  0, 1, 1, 'h00000a5c,   0, 0, 0);
	add_row(op_none,    csr_crmd,   0, ecode_int, 'hcafe0011, 0, 1, 1, 'hcafe0011, 0, 0, 0);
endtask

`endif

/* testbench/tb_wb_csr.sv */
`timescale 1ns/100ps

`include "wb_csr_settings.svh"

module tb_wb_csr
	import wb_csr_pkg::*;
();

typedef struct {
	logic [`WB_DATA_W-1:0]     pc;
	csr_op_e                   op;
	csr_num_e                  num;
	logic [`WB_DATA_W-1:0]     src;
	logic [`WB_DATA_W-1:0]     mask;
	logic                      ex;
	ecode_e                    ecode;
	logic                      gr_we;
	logic [`WB_REG_ADDR_W-1:0] dest;
	logic                      exp_we;
	logic [`WB_DATA_W-1:0]     exp_wdata;
	logic                      exp_flush;
	logic [`WB_DATA_W-1:0]     exp_fpc;
	int                        idle;
} row_t;

logic                      clk;
logic                      reset;
logic                      in_valid;
logic [`WB_DATA_W-1:0]     in_pc;
csr_op_e                   in_op;
csr_num_e                  in_csr_num;
logic [`WB_DATA_W-1:0]     in_result;
logic [`WB_DATA_W-1:0]     in_mask;
logic                      in_gr_we;
logic [`WB_REG_ADDR_W-1:0] in_dest;
logic                      in_ex;
ecode_e                    in_ecode;
logic                      allowin;
logic                      rf_we;
logic [`WB_REG_ADDR_W-1:0] rf_waddr;
logic [`WB_DATA_W-1:0]     rf_wdata;
logic                      flush;
logic [`WB_DATA_W-1:0]     flush_pc;

row_t                  rows[$];
logic [`WB_DATA_W-1:0] last_pc;
int                    mismatches = 0;
int                    other_errors = 0;
int                    cycles = 0;
int                    cycle_limit = 0;

wb_csr_top uut (
	.clk        (clk),
	.reset      (reset),
	.in_valid   (in_valid),
	.in_pc      (in_pc),
	.in_op      (in_op),
	.in_csr_num (in_csr_num),
	.in_result  (in_result),
	.in_mask    (in_mask),
	.in_gr_we   (in_gr_we),
	.in_dest    (in_dest),
	.in_ex      (in_ex),
	.in_ecode   (in_ecode),
	.allowin    (allowin),
	.rf_we      (rf_we),
	.rf_waddr   (rf_waddr),
	.rf_wdata   (rf_wdata),
	.flush      (flush),
	.flush_pc   (flush_pc)
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// Table helpers
//////////////////////////////////////////////////////////////////////

// PC and destination follow the row index
task automatic add_row(input csr_op_e op, input csr_num_e num, input logic ex,
		input ecode_e ecode, input logic [`WB_DATA_W-1:0] src,
		input logic [`WB_DATA_W-1:0] mask, input logic gr_we, input logic exp_we,
		input logic [`WB_DATA_W-1:0] exp_wdata, input logic exp_flush,
		input logic [`WB_DATA_W-1:0] exp_fpc, input int idle);
	row_t r;
	r.pc        = 32'h1c00_0000 + (rows.size() << 2);
	r.op        = op;
	r.num       = num;
	r.src       = src;
	r.mask      = mask;
	r.ex        = ex;
	r.ecode     = ecode;
	r.gr_we     = gr_we;
	r.dest      = `WB_REG_ADDR_W'(rows.size() % 32);
	r.exp_we    = exp_we;
	r.exp_wdata = exp_wdata;
	r.exp_flush = exp_flush;
	r.exp_fpc   = exp_fpc;
	r.idle      = idle;
	last_pc     = r.pc;
	rows.push_back(r);
endtask

`include "tb_wb_csr_vectors.svh"

task automatic drive_row(input row_t r);
	in_valid   = 1'b1;
	in_pc      = r.pc;
	in_op      = r.op;
	in_csr_num = r.num;
	in_result  = r.src;
	in_mask    = r.mask;
	in_gr_we   = r.gr_we;
	in_dest    = r.dest;
	in_ex      = r.ex;
	in_ecode   = r.ecode;
endtask

task automatic drive_idle();
	in_valid = 1'b0;
	in_op    = op_none;
	in_ex    = 1'b0;
	in_gr_we = 1'b0;
endtask

task automatic compare_bit(input string name, input int idx, input logic got,
		input logic exp);
	assert (got === exp) else begin
		$display("MISMATCH at %0t: row %0d %s got %b expected %b",
			$time, idx, name, got, exp);
		mismatches++;
	end
endtask

task automatic compare_word(input string name, input int idx,
		input logic [`WB_DATA_W-1:0] got, input logic [`WB_DATA_W-1:0] exp);
	assert (got === exp) else begin
		$display("MISMATCH at %0t: row %0d %s got %h expected %h",
			$time, idx, name, got, exp);
		mismatches++;
	end
endtask

// Outputs belong to the item held since the last rising edge
task automatic check_row(input int idx);
	row_t r;
	r = rows[idx];
	compare_bit("allowin", idx, allowin, 1'b1);
	compare_bit("rf_we", idx, rf_we, r.exp_we);
	compare_bit("flush", idx, flush, r.exp_flush);
	if (r.exp_we) begin
		compare_word("rf_wdata", idx, rf_wdata, r.exp_wdata);
		compare_word("rf_waddr", idx, rf_waddr, r.dest);
	end
	if (r.exp_flush)
		compare_word("flush_pc", idx, flush_pc, r.exp_fpc);
endtask

//////////////////////////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////////////////////////

initial begin
	int total_idle;
	total_idle = 0;
	reset      = 1'b1;
	in_pc      = '0;
	in_result  = '0;
	in_mask    = '0;
	in_dest    = '0;
	in_csr_num = csr_crmd;
	in_ecode   = ecode_int;
	drive_idle();
	void'($urandom(32446));
	load_vectors();
	foreach (rows[k])
		total_idle += rows[k].idle;
	cycle_limit = 10 + rows.size() + total_idle + 40;

	repeat (10) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;
	compare_bit("allowin", -1, allowin, 1'b1);
	compare_bit("rf_we", -1, rf_we, 1'b0);
	compare_bit("flush", -1, flush, 1'b0);
	drive_row(rows[0]);

	for (int i = 0; i < rows.size(); i++) begin
		@(posedge clk);
		@(negedge clk);
		check_row(i);
		drive_idle();
		repeat (rows[i].idle) @(negedge clk);
		if (i + 1 < rows.size())
			drive_row(rows[i + 1]);
	end

	@(negedge clk);
	$display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
	if (mismatches == 0 && other_errors == 0)
		$display("TEST RESULT: PASS");
	else
		$display("TEST RESULT: FAIL");
	$finish;
end

// Run limit
always @(posedge clk) begin
	if (cycle_limit > 0 && cycles >= cycle_limit) begin
		other_errors++;
		$display("Run did not finish within %0d cycles", cycle_limit);
		$display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end else begin
		cycles++;
	end
end

endmodule

/* wb_csr.f */
+incdir+hw
+incdir+testbench
hw/wb_csr_pkg.sv
hw/wb_input_reg.sv
hw/csr_file.sv
hw/csr_timer.sv
hw/wb_commit.sv
hw/wb_csr_top.sv
testbench/tb_wb_csr.sv

/* Bender.yml */
package:
  name: wb_csr

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_csr_pkg.sv
      - hw/wb_input_reg.sv
      - hw/csr_file.sv
      - hw/csr_timer.sv
      - hw/wb_commit.sv
      - hw/wb_csr_top.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_wb_csr.sv
